/* logic/lsu_pkg.sv */
// Shared widths, access sizes and request/response structs of the load/store unit
// Every RTL block refers to these by scoped name
package lsu_pkg;

  // Data and address width, one word
  localparam int XLEN = 32;
  // One enable per byte of the word
  localparam int BE_W = XLEN / 8;

  // Access size as coded by the load/store instruction
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } lsu_size_e;

  // Request as presented by the EX stage
  typedef struct packed {
    logic [XLEN-1:0] operand_a;
    logic [XLEN-1:0] operand_b;
    logic            we;
    lsu_size_e       size;
    logic            sext;
    logic [XLEN-1:0] wdata;
  } lsu_ex_req_t;

  // One data bus transaction, address always word aligned
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic            we;
    logic [BE_W-1:0] be;
    logic [XLEN-1:0] wdata;
  } lsu_bus_req_t;

  // Controls carried from the address phase to the response
  typedef struct packed {
    lsu_size_e  size;
    logic       sext;
    logic       we;
    logic [1:0] offset;
    // Low only for the first half of a split access
    logic       last;
  } lsu_wb_ctrl_t;

endpackage

/* logic/lsu_req_align.sv */
`timescale 1ns/10ps
// Turns the EX-stage request into one bus transaction per phase
// Generates byte enables, rotated write data and detects split accesses
module lsu_req_align (
  input  lsu_pkg::lsu_ex_req_t  ex_req_i,
  input  logic                  valid_0_i,
  input  logic                  split_q_i,
  output lsu_pkg::lsu_bus_req_t bus_trans_o,
  output logic                  split_o,
  output lsu_pkg::lsu_wb_ctrl_t wb_ctrl_o
);

  logic [lsu_pkg::XLEN-1:0] addr;
  logic [lsu_pkg::XLEN-1:0] addr_base;
  logic [1:0]               offset;
  logic [lsu_pkg::BE_W-1:0] be;
  logic [lsu_pkg::XLEN-1:0] wdata_rot;

  // Effective address from the two operands
  assign addr      = ex_req_i.operand_a + ex_req_i.operand_b;
  assign offset    = addr[1:0];
  assign addr_base = {addr[lsu_pkg::XLEN-1:2], 2'b00};

  ////////////////////////////////////////////////////////////
  // Byte enables
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_req_i.size)
      lsu_pkg::SIZE_BYTE: begin
        be = 4'b0001 << offset;
      end
      lsu_pkg::SIZE_HALF: begin
        // Offset 3 leaves only the top byte in the first phase
        if (split_q_i) begin
          be = 4'b0001;
        end else begin
          be = 4'b0011 << offset;
        end
      end
      default: begin
        // Second phase covers the bytes that spilled past the word
        if (split_q_i) begin
          be = ~(4'b1111 << offset);
        end else begin
          be = 4'b1111 << offset;
        end
      end
    endcase
  end

  // Rotate store data so each byte lands on its enabled lane
  always_comb begin
    case (offset)
      2'd0:    wdata_rot = ex_req_i.wdata;
      2'd1:    wdata_rot = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'd2:    wdata_rot = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata_rot = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Split detection
  ////////////////////////////////////////////////////////////

  // Only in the first phase, second phase never splits again
  always_comb begin
    split_o = 1'b0;
    if (valid_0_i && !split_q_i) begin
      if (ex_req_i.size == lsu_pkg::SIZE_WORD) begin
        split_o = (offset != 2'd0);
      end else if (ex_req_i.size == lsu_pkg::SIZE_HALF) begin
        split_o = (offset == 2'd3);
      end
    end
  end

  // Second phase goes to the next word
  assign bus_trans_o.addr  = split_q_i ? addr_base + lsu_pkg::XLEN'(4) : addr_base;
  assign bus_trans_o.we    = ex_req_i.we;
  assign bus_trans_o.be    = be;
  assign bus_trans_o.wdata = wdata_rot;

  // Controls that travel with this phase to its response
  assign wb_ctrl_o.size   = ex_req_i.size;
  assign wb_ctrl_o.sext   = ex_req_i.sext;
  assign wb_ctrl_o.we     = ex_req_i.we;
  assign wb_ctrl_o.offset = offset;
  assign wb_ctrl_o.last   = !split_o;

endmodule

/* logic/lsu_txn_ctrl.sv */
`timescale 1ns/10ps
// Bus handshake control of the load/store unit
// Counts outstanding transactions, tracks split phase and queues WB controls
module lsu_txn_ctrl #(
  parameter int DEPTH = 2
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_0_i,
  input  logic                  split_i,
  input  lsu_pkg::lsu_wb_ctrl_t wb_ctrl_i,
  input  logic                  bus_gnt_i,
  input  logic                  bus_rvalid_i,
  output logic                  bus_req_o,
  output logic                  ready_0_o,
  output logic                  valid_1_o,
  output logic                  split_q_o,
  output lsu_pkg::lsu_wb_ctrl_t wb_ctrl_o,
  output logic                  resp_first_o,
  output logic                  busy_o,
  output logic                  interruptible_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [CNT_W-1:0]      cnt_q;
  logic [CNT_W-1:0]      cnt_d;
  logic                  count_up;
  logic                  count_down;
  logic                  wait_q;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  lsu_pkg::lsu_wb_ctrl_t ctrl_mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // Request and outstanding counter
  ////////////////////////////////////////////////////////////

  // Request straight from EX while there is room
  assign bus_req_o  = valid_0_i && (cnt_q < CNT_W'(DEPTH));
  assign count_up   = bus_req_o && bus_gnt_i;
  // Responses only come for granted requests
  assign count_down = bus_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // EX released only at grant of the last phase
  assign ready_0_o = count_up && !split_i;

  // Split phase, cleared when EX drops the request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      split_q_o <= 1'b0;
    end else if (!valid_0_i) begin
      split_q_o <= 1'b0;
    end else if (count_up) begin
      split_q_o <= split_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // In-order queue of WB controls
  ////////////////////////////////////////////////////////////

  // One entry per granted transaction
  always_ff @(posedge clk) begin
    if (count_up) begin
      ctrl_mem[wr_ptr_q] <= wb_ctrl_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (count_up) begin
        if (wr_ptr_q == PTR_W'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (count_down) begin
        if (rd_ptr_q == PTR_W'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
    end
  end

  // Head entry belongs to the next response
  assign wb_ctrl_o    = ctrl_mem[rd_ptr_q];
  assign resp_first_o = !wb_ctrl_o.last;
  // First half of a split gives no WB strobe
  assign valid_1_o    = bus_rvalid_i && wb_ctrl_o.last;

  ////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////

  // Request that already waited a cycle may not be retracted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wait_q <= 1'b0;
    end else if (count_up) begin
      wait_q <= 1'b0;
    end else if (bus_req_o) begin
      wait_q <= 1'b1;
    end
  end

  assign interruptible_o = !wait_q && (cnt_q == '0);
  assign busy_o          = (cnt_q != '0) || bus_req_o;

endmodule

/* logic/lsu_rdata_align.sv */
`timescale 1ns/10ps
// Load data path of the WB stage
// Picks the addressed bytes, extends them and joins the halves of split loads
module lsu_rdata_align (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     bus_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  input  lsu_pkg::lsu_wb_ctrl_t    wb_ctrl_i,
  input  logic                     resp_first_i,
  output logic [lsu_pkg::XLEN-1:0] rdata_1_o
);

  logic [lsu_pkg::XLEN-1:0] rdata_q;
  logic [lsu_pkg::XLEN-1:0] low_word;
  logic [lsu_pkg::XLEN-1:0] shifted;
  logic                     spanned;

  // First half of a split load is held until its partner arrives
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (bus_rvalid_i && resp_first_i && !wb_ctrl_i.we) begin
      rdata_q <= bus_rdata_i;
    end
  end

  // Access crossed a word boundary, lower bytes come from the held word
  assign spanned = ((wb_ctrl_i.size == lsu_pkg::SIZE_WORD) && (wb_ctrl_i.offset != 2'd0)) ||
                   ((wb_ctrl_i.size == lsu_pkg::SIZE_HALF) && (wb_ctrl_i.offset == 2'd3));

  assign low_word = spanned ? rdata_q : bus_rdata_i;

  ////////////////////////////////////////////////////////////
  // Byte lane selection
  ////////////////////////////////////////////////////////////

  // Window over {current, low} starting at the addressed byte
  always_comb begin
    case (wb_ctrl_i.offset)
      2'd0:    shifted = low_word;
      2'd1:    shifted = {bus_rdata_i[7:0], low_word[31:8]};
      2'd2:    shifted = {bus_rdata_i[15:0], low_word[31:16]};
      default: shifted = {bus_rdata_i[23:0], low_word[31:24]};
    endcase
  end

  // Zero or sign extension by size
  always_comb begin
    case (wb_ctrl_i.size)
      lsu_pkg::SIZE_BYTE: begin
        rdata_1_o = {{24{wb_ctrl_i.sext & shifted[7]}}, shifted[7:0]};
      end
      lsu_pkg::SIZE_HALF: begin
        rdata_1_o = {{16{wb_ctrl_i.sext & shifted[15]}}, shifted[15:0]};
      end
      default: begin
        rdata_1_o = shifted;
      end
    endcase
  end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/10ps
// Load/store unit top level between EX stage, WB stage and data bus
// DEPTH sets how many bus transactions may be in flight
module lsu_top #(
  parameter int DEPTH = 2
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_0_i,
  input  lsu_pkg::lsu_ex_req_t     ex_req_i,
  output logic                     ready_0_o,
  output logic                     bus_req_o,
  output lsu_pkg::lsu_bus_req_t    bus_trans_o,
  input  logic                     bus_gnt_i,
  input  logic                     bus_rvalid_i,
  input  logic [lsu_pkg::XLEN-1:0] bus_rdata_i,
  output logic                     valid_1_o,
  output logic [lsu_pkg::XLEN-1:0] rdata_1_o,
  output logic                     busy_o,
  output logic                     interruptible_o
);

  logic                  split;
  logic                  split_q;
  logic                  resp_first;
  lsu_pkg::lsu_wb_ctrl_t wb_ctrl_ex;
  lsu_pkg::lsu_wb_ctrl_t wb_ctrl_wb;

  // Address phase shaping
  lsu_req_align u_req_align (
    .ex_req_i    (ex_req_i),
    .valid_0_i   (valid_0_i),
    .split_q_i   (split_q),
    .bus_trans_o (bus_trans_o),
    .split_o     (split),
    .wb_ctrl_o   (wb_ctrl_ex)
  );

  // Handshakes and outstanding bookkeeping
  lsu_txn_ctrl #(
    .DEPTH (DEPTH)
  ) u_txn_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .split_i         (split),
    .wb_ctrl_i       (wb_ctrl_ex),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_req_o       (bus_req_o),
    .ready_0_o       (ready_0_o),
    .valid_1_o       (valid_1_o),
    .split_q_o       (split_q),
    .wb_ctrl_o       (wb_ctrl_wb),
    .resp_first_o    (resp_first),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  // Response data to WB
  lsu_rdata_align u_rdata_align (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_rdata_i  (bus_rdata_i),
    .wb_ctrl_i    (wb_ctrl_wb),
    .resp_first_i (resp_first),
    .rdata_1_o    (rdata_1_o)
  );

endmodule

/* verif/lsu_assert.sv */
`timescale 1ns/10ps
// Bus handshake and in-flight limit rules, bound into every lsu_top
module lsu_assert #(
  parameter int DEPTH = 2
) (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  bus_req_i,
  input logic                  bus_gnt_i,
  input lsu_pkg::lsu_bus_req_t bus_trans_i,
  input logic                  bus_rvalid_i,
  input logic                  ready_i,
  input logic                  valid_1_i
);

  int pending;
  int open_acc;

  // Granted minus answered transactions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 0;
    end else if (bus_req_i && bus_gnt_i && !bus_rvalid_i) begin
      pending <= pending + 1;
    end else if (!(bus_req_i && bus_gnt_i) && bus_rvalid_i) begin
      pending <= pending - 1;
    end
  end

  // Accesses released to EX and not yet strobed to WB
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      open_acc <= 0;
    end else if (ready_i && !valid_1_i) begin
      open_acc <= open_acc + 1;
    end else if (!ready_i && valid_1_i) begin
      open_acc <= open_acc - 1;
    end
  end

  // Waiting request keeps its transaction
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_i && !bus_gnt_i) |=> (bus_req_i && $stable(bus_trans_i)))
    else $error("bus request dropped or changed before its grant");

  depth_limit: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_req_i && pending >= DEPTH))
    else $error("bus request raised with all slots in flight");

  // WB strobe only on a response that closes an accepted access
  wb_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    valid_1_i |-> (bus_rvalid_i && open_acc > 0))
    else $error("WB strobe without a bus response of an accepted access");

endmodule

bind lsu_top lsu_assert #(
  .DEPTH (DEPTH)
) u_assert (
  .clk          (clk),
  .rst_n        (rst_n),
  .bus_req_i    (bus_req_o),
  .bus_gnt_i    (bus_gnt_i),
  .bus_trans_i  (bus_trans_o),
  .bus_rvalid_i (bus_rvalid_i),
  .ready_i      (ready_0_o),
  .valid_1_i    (valid_1_o)
);

/* verif/lsu_tb.sv */
`timescale 1ns/10ps
// Testbench of the load/store unit, runs the accesses listed in verif/lsu_tests.txt
// A word memory with random grant back-pressure answers the data bus
module lsu_tb;

  localparam int DEPTH = 2;
  localparam logic [31:0] SEED = 32'ha3444d0c;

  // One line of the tests file
  typedef struct packed {
    logic        we;
    logic [1:0]  size;
    logic        sext;
    logic [31:0] opa;
    logic [31:0] opb;
    logic [31:0] wdata;
    logic [31:0] exp;
  } test_vec_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid_0_i;
  lsu_pkg::lsu_ex_req_t  ex_req_i;
  logic                  ready_0_o;
  logic                  bus_req_o;
  lsu_pkg::lsu_bus_req_t bus_trans_o;
  logic                  bus_gnt_i;
  logic                  bus_rvalid_i;
  logic [31:0]           bus_rdata_i;
  logic                  valid_1_o;
  logic [31:0]           rdata_1_o;
  logic                  busy_o;
  logic                  interruptible_o;

  test_vec_t   tests[$];
  string       names[$];
  // Accesses issued to the DUT and still waiting for valid_1_o
  int          pend_q[$];
  logic [31:0] rsp_q[$];
  logic [31:0] mem [64];
  int          done_cnt = 0;
  bit          tests_loaded = 1'b0;

  lsu_top #(
    .DEPTH (DEPTH)
  ) uut (
    .clk             (clk),
    .rst_n           (rst_n),
    .valid_0_i       (valid_0_i),
    .ex_req_i        (ex_req_i),
    .ready_0_o       (ready_0_o),
    .bus_req_o       (bus_req_o),
    .bus_trans_o     (bus_trans_o),
    .bus_gnt_i       (bus_gnt_i),
    .bus_rvalid_i    (bus_rvalid_i),
    .bus_rdata_i     (bus_rdata_i),
    .valid_1_o       (valid_1_o),
    .rdata_1_o       (rdata_1_o),
    .busy_o          (busy_o),
    .interruptible_o (interruptible_o)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_with_failure();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act == exp) else begin
      $display("ERROR %s: %s expected %h actual %h", test, what, exp, act);
      stop_with_failure();
    end
  endtask

  // Skips comment lines, one access per remaining line
  task automatic load_tests();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [31:0] we_v;
    logic [31:0] size_v;
    logic [31:0] sext_v;
    test_vec_t   tv;
    fd = $fopen("verif/lsu_tests.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open verif/lsu_tests.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h", name, we_v, size_v, sext_v,
                       tv.opa, tv.opb, tv.wdata, tv.exp);
        assert (code == 8) else begin
          $display("Malformed line in the tests file: %s", line);
          stop_with_failure();
        end
        tv.we   = we_v[0];
        tv.size = size_v[1:0];
        tv.sext = sext_v[0];
        tests.push_back(tv);
        names.push_back(name);
      end
    end
    $fclose(fd);
  endtask

  // Drives one access and follows its bus phases up to ready_0_o
  task automatic run_access(input int idx);
    test_vec_t   tv;
    logic [31:0] addr;
    logic [31:0] first_addr;
    logic [31:0] last_addr;
    int          phases;
    int          exp_phases;
    int          waited;
    bit          done;
    tv   = tests[idx];
    addr = tv.opa + tv.opb;
    // Word off its boundary or halfword in the top byte takes two phases
    exp_phases = ((tv.size == 2'd2 && addr[1:0] != 2'd0) ||
                  (tv.size == 2'd1 && addr[1:0] == 2'd3)) ? 2 : 1;
    ex_req_i.operand_a = tv.opa;
    ex_req_i.operand_b = tv.opb;
    ex_req_i.we        = tv.we;
    ex_req_i.size      = lsu_pkg::lsu_size_e'(tv.size);
    ex_req_i.sext      = tv.sext;
    ex_req_i.wdata     = tv.wdata;
    valid_0_i          = 1'b1;
    pend_q.push_back(idx);
    phases     = 0;
    waited     = 0;
    done       = 1'b0;
    first_addr = '0;
    last_addr  = '0;
    while (!done) begin
      @(negedge clk);
      // An open request always keeps the unit busy
      check_value(names[idx], "busy_o", 32'd1, {31'd0, busy_o});
      if (bus_req_o && bus_gnt_i) begin
        phases++;
        waited = 0;
        if (phases == 1) begin
          first_addr = bus_trans_o.addr;
        end
        last_addr = bus_trans_o.addr;
        done      = ready_0_o;
      end else begin
        assert (!ready_0_o) else begin
          $display("ready_0_o rose in %s without a bus grant", names[idx]);
          stop_with_failure();
        end
        if (bus_req_o) begin
          waited++;
        end
        // Second cycle of waiting onwards the request is committed
        if (waited >= 2) begin
          check_value(names[idx], "interruptible_o", 32'd0, {31'd0, interruptible_o});
        end
      end
    end
    @(posedge clk);
    #1;
    check_value(names[idx], "bus phases", 32'(exp_phases), 32'(phases));
    check_value(names[idx], "first address", {addr[31:2], 2'b00}, first_addr);
    check_value(names[idx], "last address",
                {addr[31:2], 2'b00} + 32'(4 * (exp_phases - 1)), last_addr);
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, bus model, response checker, watchdog
  ////////////////////////////////////////////////////////////

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #2;
      clk = ~clk;
    end
  end

  // Grant sampled mid-cycle, answered with rvalid one or more cycles later
  initial begin : bus_model
    logic [31:0]           rnd;
    logic                  granted;
    logic [5:0]            idx;
    lsu_pkg::lsu_bus_req_t trans;
    bus_gnt_i    = 1'b0;
    bus_rvalid_i = 1'b0;
    bus_rdata_i  = '0;
    rnd          = SEED;
    // Fill tag is the byte address of each word
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'h5a000000 | 32'(i * 4);
    end
    forever begin
      @(negedge clk);
      granted = bus_req_o && bus_gnt_i;
      trans   = bus_trans_o;
      @(posedge clk);
      #1;
      if (granted) begin
        idx = trans.addr[7:2];
        rsp_q.push_back(mem[idx]);
        if (trans.we) begin
          for (int b = 0; b < 4; b++) begin
            if (trans.be[b]) begin
              mem[idx][8*b +: 8] = trans.wdata[8*b +: 8];
            end
          end
        end
      end
      rnd = next_rand(rnd);
      // Head response released about every other cycle, so several stay in flight
      if (rsp_q.size() > 0 && rnd[3]) begin
        bus_rvalid_i = 1'b1;
        bus_rdata_i  = rsp_q.pop_front();
      end else begin
        bus_rvalid_i = 1'b0;
        bus_rdata_i  = '0;
      end
      // Roughly three grants in eight
      bus_gnt_i = (rnd[2:0] > 3'd4);
    end
  end

  initial begin : response_check
    int idx;
    forever begin
      @(negedge clk);
      if (valid_1_o) begin
        assert (pend_q.size() > 0) else begin
          $display("valid_1_o pulsed while no access was open");
          stop_with_failure();
        end
        idx = pend_q.pop_front();
        if (!tests[idx].we) begin
          check_value(names[idx], "load data", tests[idx].exp, rdata_1_o);
        end
        done_cnt++;
      end
    end
  end

  initial begin : watchdog
    wait (tests_loaded);
    repeat (tests.size() * 50 + 10) @(posedge clk);
    $display("Watchdog expired after %0d cycles with accesses still open",
             tests.size() * 50 + 10);
    stop_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    rst_n     = 1'b0;
    valid_0_i = 1'b0;
    ex_req_i  = '0;
    load_tests();
    tests_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset", "bus_req_o", 32'd0, {31'd0, bus_req_o});
    check_value("reset", "ready_0_o", 32'd0, {31'd0, ready_0_o});
    check_value("reset", "valid_1_o", 32'd0, {31'd0, valid_1_o});
    check_value("reset", "busy_o", 32'd0, {31'd0, busy_o});
    check_value("reset", "interruptible_o", 32'd1, {31'd0, interruptible_o});
    @(posedge clk);
    #1;
    for (int i = 0; i < tests.size(); i++) begin
      run_access(i);
    end
    valid_0_i = 1'b0;
    while (done_cnt < tests.size()) @(negedge clk);
    @(negedge clk);
    // Everything drained, unit idle again
    check_value("drain", "busy_o", 32'd0, {31'd0, busy_o});
    check_value("drain", "interruptible_o", 32'd1, {31'd0, interruptible_o});
    check_value("drain", "bus_req_o", 32'd0, {31'd0, bus_req_o});
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* verif/lsu_tests.txt */
# name we size sext operand_a operand_b wdata expected, all hex, size 0 byte 1 half 2 word
# expected is the load result and is ignored for stores
sw_a    1 2 0 00000010 00000000 11223344 00000000
lw_a    0 2 0 00000010 00000000 00000000 11223344
sw_b    1 2 0 00000010 00000004 8899aabb 00000000
lw_b    0 2 0 00000014 00000000 00000000 8899aabb
lbu_0   0 0 0 00000014 00000000 00000000 000000bb
lb_1    0 0 1 00000010 00000005 00000000 ffffffaa
lb_2    0 0 1 00000016 00000000 00000000 ffffff99
lbu_3   0 0 0 00000017 00000000 00000000 00000088
lb_pos  0 0 1 00000011 00000000 00000000 00000033
lhu_0   0 1 0 00000014 00000000 00000000 0000aabb
lh_1    0 1 1 00000015 00000000 00000000 ffff99aa
lh_2    0 1 1 00000016 00000000 00000000 ffff8899
lh_3    0 1 1 00000013 00000000 00000000 ffffbb11
sb_1    1 0 0 00000011 00000000 000000ee 00000000
sh_2    1 1 0 00000012 00000000 0000cafe 00000000
lw_m    0 2 0 fffffff0 00000020 00000000 cafeee44
sw_c    1 2 0 00000018 00000000 deadbeef 00000000
sw_mis  1 2 0 00000015 00000000 01020304 00000000
lw_mis1 0 2 0 00000015 00000000 00000000 01020304
lw_mis3 0 2 0 0000000c 00000007 00000000 0304bbca
sh_mis  1 1 0 00000017 00000000 00007788 00000000
lhu_mis 0 1 0 00000017 00000000 00000000 00007788
lw_5    0 2 0 00000014 00000000 00000000 880304bb
lw_6    0 2 0 00000018 00000000 00000000 deadbe77
lw_mis2 0 2 0 00000016 00000000 00000000 be778803

/* flist.f */
logic/lsu_pkg.sv
logic/lsu_req_align.sv
logic/lsu_txn_ctrl.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
verif/lsu_assert.sv
verif/lsu_tb.sv

/* Makefile */
# Verilator build, run and lint of the load/store unit testbench
TOP = lsu_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
